//--- include/hast_defs.svh
/* Widths, register map and reset defaults for the HastIp role.
   Included by the package and by every RTL file. */
`ifndef HAST_DEFS_SVH
`define HAST_DEFS_SVH

`define HAST_PCIE_DATA_WIDTH        128
`define HAST_SLOT_WIDTH             16
`define HAST_LINE_BYTES             64
`define HAST_BEATS_PER_LINE         4
`define HAST_MEM_ADDR_WIDTH         32
`define HAST_MEM_DATA_WIDTH         512
`define HAST_SOFTREG_ADDR_WIDTH     8
`define HAST_SOFTREG_DATA_WIDTH     64

// "HastIp", first character in the low byte
`define HAST_ROLE_ID                64'h0000_7049_7473_6148
`define HAST_ROLE_VERSION           64'd4
`define HAST_DEFAULT_SLOTS          8'd64
`define HAST_DEFAULT_BYTES_PER_SLOT 16'hFF80

`define HAST_REG_ID                 8'd0
`define HAST_REG_VERSION            8'd1
`define HAST_REG_SLOTS              8'd2
`define HAST_REG_SLOT_BYTES         8'd3
`define HAST_REG_WRITE_ADDR         8'd4
`define HAST_REG_READ_ADDR          8'd5
`define HAST_REG_CYCLES             8'd6
`define HAST_REG_ACCEPTED           8'd7
`define HAST_REG_RECEIVED           8'd8

`endif

//--- src/hast_pkg.sv
/* Bus and record types shared by the role RTL and its testbench */
`default_nettype none
`include "hast_defs.svh"

package hast_pkg;

    typedef struct packed {
        logic                             valid;
        logic [`HAST_SLOT_WIDTH-1:0]      slot;
        logic [`HAST_PCIE_DATA_WIDTH-1:0] data;
        logic                             last;
    } pcie_packet_t;

    typedef struct packed {
        logic                            valid;
        logic                            is_write;
        logic [`HAST_MEM_ADDR_WIDTH-1:0] addr;
        logic [`HAST_MEM_DATA_WIDTH-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                            valid;
        logic [`HAST_MEM_DATA_WIDTH-1:0] data;
    } mem_resp_t;

    typedef struct packed {
        logic                                valid;
        logic                                is_write;
        logic [`HAST_SOFTREG_ADDR_WIDTH-1:0] addr;
        logic [`HAST_SOFTREG_DATA_WIDTH-1:0] data;
    } softreg_req_t;

    typedef struct packed {
        logic                                valid;
        logic [`HAST_SOFTREG_DATA_WIDTH-1:0] data;
    } softreg_resp_t;

    // First beat of an inbound slice, member_id in bits 31:0
    typedef struct packed {
        logic [31:0] slice_count;
        logic [31:0] slice_index;
        logic [31:0] payload_cells;
        logic [31:0] member_id;
    } slice_header_t;

    typedef struct packed {
        logic [`HAST_MEM_ADDR_WIDTH-1:0] write_addr;
        logic [31:0]                     accepted_slices;
        logic [31:0]                     received_bytes;
    } load_status_t;

    typedef struct packed {
        logic [7:0]  allowed_slots;
        logic [15:0] bytes_per_slot;
    } role_config_t;

endpackage

`default_nettype wire

//--- src/slice_receiver.sv
/* Load engine. Takes header-led slices from PCIe, packs beats into memory lines,
   writes each slice at its slot offset and answers with a two-beat acknowledge. */
`timescale 1ns/1ps
`default_nettype none
`include "hast_defs.svh"

module slice_receiver import hast_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          start,
    input  wire pcie_packet_t  pcie_in,
    input  wire role_config_t  cfg,
    input  wire logic          mem_req_grant,
    input  wire logic          pcie_grant,
    output logic               pcie_full,
    output mem_req_t           mem_req,
    output pcie_packet_t       pcie_out,
    output load_status_t       status,
    output slice_header_t      header,
    output logic               done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_BEAT,
        S_WRITE,
        S_ACK0,
        S_ACK1,
        S_DONE
    } state_t;

    state_t                           state;
    slice_header_t                    in_hdr;
    logic [`HAST_SLOT_WIDTH-1:0]      hdr_slot;
    logic [1:0]                       beat;
    logic [`HAST_MEM_DATA_WIDTH-1:0]  line;
    logic                             line_last;
    logic                             taken;
    logic                             all_accepted;

    assign in_hdr = pcie_in.data;
    // Input is open only while waiting for a header or a data beat
    assign pcie_full = !(state == S_IDLE || state == S_HEADER || state == S_BEAT);
    assign taken = pcie_in.valid && !pcie_full;
    assign all_accepted = (status.accepted_slices == header.slice_count);
    assign done = (state == S_ACK1) && pcie_grant && all_accepted;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            beat <= '0;
            status <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start) begin
                        status <= '0;
                        state <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    if (taken) begin
                        status.write_addr <= cfg.bytes_per_slot * in_hdr.slice_index;
                        status.accepted_slices <= status.accepted_slices + 32'd1;
                        beat <= '0;
                        state <= S_BEAT;
                    end
                end
                S_BEAT: begin
                    if (taken) begin
                        beat <= beat + 2'd1;
                        if (beat == 2'd3) begin
                            state <= S_WRITE;
                        end
                    end
                end
                S_WRITE: begin
                    if (mem_req_grant) begin
                        status.write_addr <= status.write_addr + `HAST_LINE_BYTES;
                        status.received_bytes <= status.received_bytes + `HAST_LINE_BYTES;
                        state <= line_last ? S_ACK0 : S_BEAT;
                    end
                end
                S_ACK0: begin
                    if (pcie_grant) begin
                        state <= S_ACK1;
                    end
                end
                S_ACK1: begin
                    if (pcie_grant) begin
                        state <= all_accepted ? S_DONE : S_HEADER;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Header and line payload
    always_ff @(posedge clk) begin
        if (state == S_HEADER && taken) begin
            header <= in_hdr;
            hdr_slot <= pcie_in.slot;
        end
        if (state == S_BEAT && taken) begin
            line[beat*`HAST_PCIE_DATA_WIDTH +: `HAST_PCIE_DATA_WIDTH] <= pcie_in.data;
            line_last <= pcie_in.last;
        end
    end

    always_comb begin
        mem_req.valid = (state == S_WRITE);
        mem_req.is_write = 1'b1;
        mem_req.addr = status.write_addr;
        mem_req.data = line;
    end

    // Acknowledge echoes the header, then a zero beat closes the packet
    always_comb begin
        pcie_out.valid = (state == S_ACK0) || (state == S_ACK1);
        pcie_out.slot = hdr_slot;
        pcie_out.data = (state == S_ACK0) ? header : slice_header_t'('0);
        pcie_out.last = (state == S_ACK1);
    end

    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_req_grant |=> $stable(mem_req));

    a_pcie_out_stable: assert property (@(posedge clk) disable iff (rst)
        pcie_out.valid && !pcie_grant |=> $stable(pcie_out));

endmodule

`default_nettype wire

//--- src/result_sender.sv
/* Readback engine. Reads the loaded bytes back line by line and sends them as
   result slices, each led by a header, with the slot rotating over allowed_slots. */
`timescale 1ns/1ps
`default_nettype none
`include "hast_defs.svh"

module result_sender import hast_pkg::*; (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            start,
    input  wire role_config_t                    cfg,
    input  wire logic [`HAST_MEM_ADDR_WIDTH-1:0] total_bytes,
    input  wire logic [31:0]                     member_id,
    input  wire logic [31:0]                     payload_cells,
    input  wire logic                            mem_req_grant,
    input  wire mem_resp_t                       mem_resp,
    input  wire logic                            pcie_grant,
    output mem_req_t                             mem_req,
    output logic                                 mem_resp_grant,
    output pcie_packet_t                         pcie_out,
    output logic [`HAST_MEM_ADDR_WIDTH-1:0]      read_addr,
    output logic                                 done
);

    typedef enum logic [2:0] {
        T_IDLE,
        T_HEADER,
        T_RD_REQ,
        T_RD_WAIT,
        T_BEAT,
        T_NEXT
    } state_t;

    state_t                          state;
    logic [`HAST_SLOT_WIDTH-1:0]     slot;
    logic [31:0]                     slice_idx;
    logic [31:0]                     read_len;
    logic [1:0]                      beat;
    logic [31:0]                     remaining;
    logic [31:0]                     slot_bytes;
    logic [31:0]                     slice_bytes;
    logic                            final_line;
    logic                            line_sent;

    assign remaining = total_bytes - read_addr;
    assign slot_bytes = {16'd0, cfg.bytes_per_slot};
    assign slice_bytes = (remaining < slot_bytes) ? remaining : slot_bytes;
    // Read address and budget already advanced when the line was requested
    assign final_line = (read_addr == total_bytes) || (read_len == '0);
    assign line_sent = (state == T_BEAT) && (beat == 2'd3) && pcie_grant;
    assign mem_resp_grant = line_sent;
    assign done = (state == T_NEXT) && (read_addr == total_bytes);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= T_IDLE;
            read_addr <= '0;
            slot <= '0;
            slice_idx <= '0;
            read_len <= '0;
            beat <= '0;
        end else begin
            case (state)
                T_IDLE: begin
                    if (start) begin
                        read_addr <= '0;
                        slot <= '0;
                        slice_idx <= '0;
                        state <= T_HEADER;
                    end
                end
                T_HEADER: begin
                    if (pcie_grant) begin
                        read_len <= slice_bytes;
                        state <= T_RD_REQ;
                    end
                end
                T_RD_REQ: begin
                    if (mem_req_grant) begin
                        read_addr <= read_addr + `HAST_LINE_BYTES;
                        read_len <= read_len - `HAST_LINE_BYTES;
                        state <= T_RD_WAIT;
                    end
                end
                T_RD_WAIT: begin
                    if (mem_resp.valid) begin
                        beat <= '0;
                        state <= T_BEAT;
                    end
                end
                T_BEAT: begin
                    if (pcie_grant) begin
                        beat <= beat + 2'd1;
                    end
                    if (line_sent) begin
                        state <= final_line ? T_NEXT : T_RD_REQ;
                    end
                end
                T_NEXT: begin
                    if (slot + 16'd1 >= {8'd0, cfg.allowed_slots}) begin
                        slot <= '0;
                    end else begin
                        slot <= slot + 16'd1;
                    end
                    slice_idx <= slice_idx + 32'd1;
                    state <= (read_addr == total_bytes) ? T_IDLE : T_HEADER;
                end
                default: state <= T_IDLE;
            endcase
        end
    end

    always_comb begin
        mem_req.valid = (state == T_RD_REQ);
        mem_req.is_write = 1'b0;
        mem_req.addr = read_addr;
        mem_req.data = '0;
    end

    // Response data stays on the bus until the fourth beat is granted
    always_comb begin
        pcie_out.valid = (state == T_HEADER) || (state == T_BEAT);
        pcie_out.slot = slot;
        if (state == T_HEADER) begin
            pcie_out.data = {slice_bytes, slice_idx, payload_cells, member_id};
        end else begin
            pcie_out.data = mem_resp.data[beat*`HAST_PCIE_DATA_WIDTH +: `HAST_PCIE_DATA_WIDTH];
        end
        pcie_out.last = (state == T_BEAT) && (beat == 2'd3) && final_line;
    end

    a_one_access: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid |-> !mem_resp.valid);

endmodule

`default_nettype wire

//--- src/role_sequencer.sv
/* Phase control for the role. Starts the load and then the readback, and gives
   the memory and PCIe output ports to the engine of the current phase. */
`timescale 1ns/1ps
`default_nettype none
`include "hast_defs.svh"

module role_sequencer import hast_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          load_done,
    input  wire logic          send_done,
    input  wire mem_req_t      rx_mem_req,
    input  wire mem_req_t      tx_mem_req,
    input  wire pcie_packet_t  rx_pcie_out,
    input  wire pcie_packet_t  tx_pcie_out,
    input  wire logic          tx_mem_resp_grant,
    input  wire logic          mem_req_grant,
    input  wire logic          pcie_grant,
    output logic               load_start,
    output logic               send_start,
    output mem_req_t           mem_req,
    output logic               mem_resp_grant,
    output pcie_packet_t       pcie_out,
    output logic               rx_mem_req_grant,
    output logic               tx_mem_req_grant,
    output logic               rx_pcie_grant,
    output logic               tx_pcie_grant
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_LOAD,
        P_SEND
    } phase_t;

    phase_t phase;
    logic   rx_owns;
    logic   tx_owns;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= P_IDLE;
        end else begin
            case (phase)
                P_IDLE: phase <= P_LOAD;
                P_LOAD: phase <= load_done ? P_SEND : P_LOAD;
                P_SEND: phase <= send_done ? P_IDLE : P_SEND;
                default: phase <= P_IDLE;
            endcase
        end
    end

    assign rx_owns = (phase == P_LOAD);
    assign tx_owns = (phase == P_SEND);
    assign load_start = (phase == P_IDLE);
    // Readback starts on the edge that ends the load
    assign send_start = rx_owns && load_done;

    always_comb begin
        mem_req = '0;
        pcie_out = '0;
        if (rx_owns) begin
            mem_req = rx_mem_req;
            pcie_out = rx_pcie_out;
        end else if (tx_owns) begin
            mem_req = tx_mem_req;
            pcie_out = tx_pcie_out;
        end
    end

    assign mem_resp_grant = tx_owns && tx_mem_resp_grant;
    assign rx_mem_req_grant = rx_owns && mem_req_grant;
    assign tx_mem_req_grant = tx_owns && mem_req_grant;
    assign rx_pcie_grant = rx_owns && pcie_grant;
    assign tx_pcie_grant = tx_owns && pcie_grant;

    a_rx_quiet: assert property (@(posedge clk) disable iff (rst)
        !rx_owns |-> !rx_mem_req.valid && !rx_pcie_out.valid);

    a_tx_quiet: assert property (@(posedge clk) disable iff (rst)
        !tx_owns |-> !tx_mem_req.valid && !tx_pcie_out.valid);

endmodule

`default_nettype wire

//--- src/softreg_block.sv
/* Soft register file. Holds the slot configuration, answers reads one cycle
   after the request and keeps a free-running cycle counter. */
`timescale 1ns/1ps
`default_nettype none
`include "hast_defs.svh"

module softreg_block import hast_pkg::*; (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire softreg_req_t                    softreg_req,
    input  wire load_status_t                    status,
    input  wire logic [`HAST_MEM_ADDR_WIDTH-1:0] read_addr,
    output softreg_resp_t                        softreg_resp,
    output role_config_t                         cfg
);

    logic [`HAST_SOFTREG_DATA_WIDTH-1:0] cycles;
    logic                                wr;
    logic                                rd;

    assign wr = softreg_req.valid && softreg_req.is_write;
    assign rd = softreg_req.valid && !softreg_req.is_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.allowed_slots <= `HAST_DEFAULT_SLOTS;
            cfg.bytes_per_slot <= `HAST_DEFAULT_BYTES_PER_SLOT;
        end else if (wr) begin
            case (softreg_req.addr)
                `HAST_REG_SLOTS: begin
                    if (softreg_req.data[7:0] != 8'd0) begin
                        cfg.allowed_slots <= softreg_req.data[7:0];
                    end
                end
                // Whole lines per slot
                `HAST_REG_SLOT_BYTES: cfg.bytes_per_slot <= {softreg_req.data[15:6], 6'd0};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            softreg_resp.valid <= 1'b0;
        end else begin
            softreg_resp.valid <= rd;
        end
    end

    always_ff @(posedge clk) begin
        case (softreg_req.addr)
            `HAST_REG_ID:         softreg_resp.data <= `HAST_ROLE_ID;
            `HAST_REG_VERSION:    softreg_resp.data <= `HAST_ROLE_VERSION;
            `HAST_REG_SLOTS:      softreg_resp.data <= {56'd0, cfg.allowed_slots};
            `HAST_REG_SLOT_BYTES: softreg_resp.data <= {48'd0, cfg.bytes_per_slot};
            `HAST_REG_WRITE_ADDR: softreg_resp.data <= {32'd0, status.write_addr};
            `HAST_REG_READ_ADDR:  softreg_resp.data <= {32'd0, read_addr};
            `HAST_REG_CYCLES:     softreg_resp.data <= cycles;
            `HAST_REG_ACCEPTED:   softreg_resp.data <= {32'd0, status.accepted_slices};
            `HAST_REG_RECEIVED:   softreg_resp.data <= {32'd0, status.received_bytes};
            default:              softreg_resp.data <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/hast_role.sv
/* Top of the HastIp role. Connects the load and readback engines, the phase
   sequencer and the soft registers to the PCIe, memory and register ports. */
`timescale 1ns/1ps
`default_nettype none
`include "hast_defs.svh"

module hast_role import hast_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire pcie_packet_t  pcie_packet_in,
    input  wire logic          pcie_grant,
    input  wire logic          mem_req_grant,
    input  wire mem_resp_t     mem_resp,
    input  wire softreg_req_t  softreg_req,
    output logic               pcie_full,
    output pcie_packet_t       pcie_packet_out,
    output mem_req_t           mem_req,
    output logic               mem_resp_grant,
    output softreg_resp_t      softreg_resp
);

    logic                            load_start;
    logic                            send_start;
    logic                            load_done;
    logic                            send_done;
    mem_req_t                        rx_mem_req;
    mem_req_t                        tx_mem_req;
    pcie_packet_t                    rx_pcie_out;
    pcie_packet_t                    tx_pcie_out;
    logic                            tx_mem_resp_grant;
    logic                            rx_mem_req_grant;
    logic                            tx_mem_req_grant;
    logic                            rx_pcie_grant;
    logic                            tx_pcie_grant;
    role_config_t                    cfg;
    load_status_t                    status;
    slice_header_t                   header;
    logic [`HAST_MEM_ADDR_WIDTH-1:0] read_addr;

    slice_receiver u_slice_receiver (
        .clk(clk), .rst(rst), .start(load_start), .pcie_in(pcie_packet_in), .cfg(cfg),
        .mem_req_grant(rx_mem_req_grant), .pcie_grant(rx_pcie_grant),
        .pcie_full(pcie_full), .mem_req(rx_mem_req), .pcie_out(rx_pcie_out),
        .status(status), .header(header), .done(load_done)
    );

    result_sender u_result_sender (
        .clk(clk), .rst(rst), .start(send_start), .cfg(cfg),
        .total_bytes(status.received_bytes), .member_id(header.member_id),
        .payload_cells(header.payload_cells), .mem_req_grant(tx_mem_req_grant),
        .mem_resp(mem_resp), .pcie_grant(tx_pcie_grant), .mem_req(tx_mem_req),
        .mem_resp_grant(tx_mem_resp_grant), .pcie_out(tx_pcie_out),
        .read_addr(read_addr), .done(send_done)
    );

    role_sequencer u_role_sequencer (
        .clk(clk), .rst(rst), .load_done(load_done), .send_done(send_done),
        .rx_mem_req(rx_mem_req), .tx_mem_req(tx_mem_req),
        .rx_pcie_out(rx_pcie_out), .tx_pcie_out(tx_pcie_out),
        .tx_mem_resp_grant(tx_mem_resp_grant), .mem_req_grant(mem_req_grant),
        .pcie_grant(pcie_grant), .load_start(load_start), .send_start(send_start),
        .mem_req(mem_req), .mem_resp_grant(mem_resp_grant), .pcie_out(pcie_packet_out),
        .rx_mem_req_grant(rx_mem_req_grant), .tx_mem_req_grant(tx_mem_req_grant),
        .rx_pcie_grant(rx_pcie_grant), .tx_pcie_grant(tx_pcie_grant)
    );

    softreg_block u_softreg_block (
        .clk(clk), .rst(rst), .softreg_req(softreg_req), .status(status),
        .read_addr(read_addr), .softreg_resp(softreg_resp), .cfg(cfg)
    );

endmodule

`default_nettype wire

//--- verification/tb_memory_model.sv
/* Behavioral memory for the role's memory port. Sparse line storage,
   grants and read responses after a random 0 to 3 cycle wait. */
`timescale 1ns/1ps
`default_nettype none
`include "hast_defs.svh"

module tb_memory_model import hast_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire mem_req_t  mem_req,
    input  wire logic      mem_resp_grant,
    output logic           mem_req_grant,
    output mem_resp_t      mem_resp
);

    logic [`HAST_MEM_DATA_WIDTH-1:0] mem [logic [31:0]];
    logic [15:0]                     lfsr = 16'd20;

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic int pick_delay();
        int d;
        d = next_bit();
        d = d * 2 + next_bit();
        return d;
    endfunction

    // Unwritten lines read back a pattern built from the byte address
    function automatic logic [`HAST_MEM_DATA_WIDTH-1:0] read_line(input logic [31:0] addr);
        logic [31:0] key;
        key = addr / `HAST_LINE_BYTES;
        if (mem.exists(key)) begin
            return mem[key];
        end
        return {16{addr}};
    endfunction

    initial begin
        logic                            is_read;
        logic [`HAST_MEM_DATA_WIDTH-1:0] rd_data;
        mem_req_grant = 1'b0;
        mem_resp = '0;
        forever begin
            @(posedge clk);
            if (!rst && mem_req.valid) begin
                repeat (pick_delay()) @(posedge clk);
                mem_req_grant <= 1'b1;
                is_read = !mem_req.is_write;
                if (mem_req.is_write) begin
                    mem[mem_req.addr / `HAST_LINE_BYTES] = mem_req.data;
                end else begin
                    rd_data = read_line(mem_req.addr);
                end
                @(posedge clk);
                mem_req_grant <= 1'b0;
                if (is_read) begin
                    // Response only after the request edge has completed
                    repeat (pick_delay()) @(posedge clk);
                    mem_resp <= {1'b1, rd_data};
                    @(posedge clk);
                    while (!mem_resp_grant) @(posedge clk);
                    mem_resp <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_hast_role.sv
/* Directed testbench for the role. Loads two slices over PCIe, checks the
   acknowledges, memory contents, readback slices and soft registers. */
`timescale 1ns/1ps
`default_nettype none
`include "hast_defs.svh"

module tb_hast_role import hast_pkg::*;;

    // Two loaded slices with their acks, then two result slices
    localparam int TEST_BEATS = 2 * (1 + 8 + 2) + 2 * (1 + 8);
    localparam int CYCLES_PER_BEAT = 16;
    localparam int TIMEOUT_NS = (TEST_BEATS * CYCLES_PER_BEAT + 20) * 4;
    localparam logic [31:0] MEMBER = 32'h4D45_4D31;
    localparam logic [31:0] CELLS = 32'd24;

    logic          clk;
    logic          rst;
    pcie_packet_t  pcie_packet_in;
    logic          pcie_grant;
    logic          mem_req_grant;
    mem_resp_t     mem_resp;
    softreg_req_t  softreg_req;
    logic          pcie_full;
    pcie_packet_t  pcie_packet_out;
    mem_req_t      mem_req;
    logic          mem_resp_grant;
    softreg_resp_t softreg_resp;

    logic [15:0]   lfsr;
    logic [127:0]  beats [16];
    pcie_packet_t  out_q [$];
    int            errors;

    hast_role u_hast_role (
        .clk(clk), .rst(rst), .pcie_packet_in(pcie_packet_in), .pcie_grant(pcie_grant),
        .mem_req_grant(mem_req_grant), .mem_resp(mem_resp), .softreg_req(softreg_req),
        .pcie_full(pcie_full), .pcie_packet_out(pcie_packet_out), .mem_req(mem_req),
        .mem_resp_grant(mem_resp_grant), .softreg_resp(softreg_resp)
    );

    tb_memory_model u_mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_resp_grant(mem_resp_grant),
        .mem_req_grant(mem_req_grant), .mem_resp(mem_resp)
    );

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ps: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [63:0] data);
        softreg_req <= '{valid: 1'b1, is_write: 1'b1, addr: addr, data: data};
        @(posedge clk);
        softreg_req <= '0;
        @(posedge clk);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [63:0] data);
        softreg_req <= '{valid: 1'b1, is_write: 1'b0, addr: addr, data: 64'd0};
        @(posedge clk);
        softreg_req <= '0;
        @(posedge clk);
        assert (softreg_resp.valid) else begin
            errors++;
            $display("Register read at address %0d got no response", addr);
        end
        data = softreg_resp.data;
    endtask

    // Holds the beat until an edge where the input was open
    task automatic send_beat(input logic [15:0] slot, input logic [127:0] data,
                             input logic last);
        pcie_packet_in <= '{valid: 1'b1, slot: slot, data: data, last: last};
        @(posedge clk);
        while (pcie_full) @(posedge clk);
    endtask

    task automatic wait_out(input int n);
        while (out_q.size() < n) @(posedge clk);
    endtask

    task automatic test_registers();
        logic [63:0] id;
        logic [63:0] got;
        string       name;
        name = "HastIp";
        id = '0;
        for (int i = 0; i < name.len(); i++) begin
            id[8*i +: 8] = name[i];
        end
        read_reg(8'd0, got);
        check_value("reg id", got, id);
        read_reg(8'd1, got);
        check_value("reg version", got, 64'd4);
        write_reg(8'd3, 64'd130);
        read_reg(8'd3, got);
        check_value("reg slot_bytes", got, 64'd128);
        write_reg(8'd2, 64'd3);
        read_reg(8'd2, got);
        check_value("reg slots", got, 64'd3);
    endtask

    task automatic test_load_acks();
        logic [15:0]   slots [2];
        slice_header_t hdr;
        pcie_packet_t  p;
        slots[0] = 16'd5;
        slots[1] = 16'd9;
        for (int s = 0; s < 2; s++) begin
            hdr = '{slice_count: 32'd2, slice_index: s, payload_cells: CELLS,
                    member_id: MEMBER};
            send_beat(slots[s], hdr, 1'b0);
            for (int k = 0; k < 8; k++) begin
                send_beat(slots[s], beats[s*8 + k], k == 7);
            end
            pcie_packet_in <= '0;
            wait_out(2);
            p = out_q.pop_front();
            check_value("ack0 slot", p.slot, slots[s]);
            check_value("ack0 data", p.data, hdr);
            check_value("ack0 last", p.last, 1'b0);
            p = out_q.pop_front();
            check_value("ack1 slot", p.slot, slots[s]);
            check_value("ack1 data", p.data, 128'd0);
            check_value("ack1 last", p.last, 1'b1);
        end
    endtask

    // Load counters clear when the role restarts its load after readback
    task automatic test_load_status();
        logic [63:0] got;
        // Input stays closed while the readback runs
        check_value("pcie_full", pcie_full, 1'b1);
        read_reg(8'd7, got);
        check_value("reg accepted", got, 64'd2);
        read_reg(8'd8, got);
        check_value("reg received", got, 64'd256);
        read_reg(8'd4, got);
        check_value("reg write_addr", got, 64'd256);
    endtask

    task automatic test_memory_placement();
        logic [511:0] line;
        for (int l = 0; l < 4; l++) begin
            line = {beats[l*4 + 3], beats[l*4 + 2], beats[l*4 + 1], beats[l*4]};
            check_value("memory line", u_mem.read_line(l * 64), line);
        end
    endtask

    task automatic test_readback();
        pcie_packet_t p;
        for (int r = 0; r < 2; r++) begin
            wait_out(9);
            p = out_q.pop_front();
            check_value("result header slot", p.slot, r);
            check_value("result header", p.data, {32'd128, 32'(r), CELLS, MEMBER});
            check_value("result header last", p.last, 1'b0);
            for (int k = 0; k < 8; k++) begin
                p = out_q.pop_front();
                check_value("result slot", p.slot, r);
                check_value("result data", p.data, beats[r*8 + k]);
                check_value("result last", p.last, k == 7);
            end
        end
    endtask

    task automatic test_read_address();
        logic [63:0] got;
        read_reg(8'd5, got);
        check_value("reg read_addr", got, 64'd256);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Output grant withheld about a quarter of the time
    initial begin
        pcie_grant = 1'b0;
        forever begin
            @(posedge clk);
            pcie_grant <= next_bit() | next_bit();
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (!rst && pcie_packet_out.valid && pcie_grant) begin
                out_q.push_back(pcie_packet_out);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with %0d errors", TIMEOUT_NS, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        errors = 0;
        lfsr = 16'd20;
        rst = 1'b1;
        pcie_packet_in = '0;
        softreg_req = '0;
        for (int i = 0; i < 16; i++) begin
            for (int b = 0; b < 128; b++) begin
                beats[i][b] = next_bit();
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_registers();
        test_load_acks();
        test_load_status();
        test_memory_placement();
        test_readback();
        test_read_address();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hast_role.f
+incdir+include
src/hast_pkg.sv
src/slice_receiver.sv
src/result_sender.sv
src/role_sequencer.sv
src/softreg_block.sv
src/hast_role.sv
verification/tb_memory_model.sv
verification/tb_hast_role.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the role testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f hast_role.f --top-module tb_hast_role -o sim_hast_role

./obj_dir/sim_hast_role > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
